/* dm_pkg.sv */
package dm_pkg;

    typedef logic [31:0] dm_word_t;
    typedef logic [6:0]  dmi_addr_t;
    typedef logic [11:0] mem_addr_t;

    typedef enum logic [2:0] {
        CMDERR_NONE       = 3'd0,
        CMDERR_BUSY       = 3'd1,
        CMDERR_NOTSUP     = 3'd2,
        CMDERR_EXCEPTION  = 3'd3,
        CMDERR_HALTRESUME = 3'd4
    } cmderr_t;

    // One-cycle request from the debugger
    typedef struct packed {
        logic      wen;
        logic      ren;
        dmi_addr_t addr;
        dm_word_t  data;
    } dmi_req_t;

    typedef struct packed {
        logic       write;
        mem_addr_t  addr;
        dm_word_t   wdata;
        logic [3:0] strb;
    } mem_req_t;

    typedef struct packed {
        logic     err;
        dm_word_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic halt_wr;
        logic going_wr;
        logic resuming_wr;
        logic exception_wr;
    } core_evt_t;

    typedef struct packed {
        logic       en;
        logic [3:0] idx;
        dm_word_t   wdata;
        logic [3:0] strb;
    } bank_wr_t;

    typedef struct packed {
        logic allhalt;
        logic anyhalt;
        logic allresumeack;
        logic anyresumeack;
    } dm_status_t;

    localparam mem_addr_t ADDR_HALT      = 12'h100;
    localparam mem_addr_t ADDR_GOING     = 12'h104;
    localparam mem_addr_t ADDR_RESUMING  = 12'h108;
    localparam mem_addr_t ADDR_EXCEPTION = 12'h10C;
    localparam mem_addr_t ADDR_WHERETO   = 12'h300;
    localparam mem_addr_t ADDR_PROGBUF   = 12'h340;
    localparam mem_addr_t ADDR_DATA      = 12'h380;
    localparam mem_addr_t ADDR_FLAGS     = 12'h400;

    localparam dmi_addr_t DMI_DATA0        = 7'h04;
    localparam dmi_addr_t DMI_DMCONTROL    = 7'h10;
    localparam dmi_addr_t DMI_ABSTRACTCS   = 7'h16;
    localparam dmi_addr_t DMI_COMMAND      = 7'h17;
    localparam dmi_addr_t DMI_ABSTRACTAUTO = 7'h18;
    localparam dmi_addr_t DMI_PROGBUF0     = 7'h20;

    localparam dm_word_t    WHERETO_INSN = 32'h0100006f; // jal x0, +0x10
    localparam logic [15:0] REGNO_LIMIT  = 16'h1040;
    localparam int          NSCRATCH     = 2;

endpackage

/* dm_core_port.sv */
`timescale 1ns/1ps

module dm_core_port #(
    parameter int DATA_COUNT    = 12,
    parameter int PROGBUF_COUNT = 16
) (
    input  logic               dm_clk,
    input  logic               dm_rst_n,
    input  dm_pkg::mem_req_t   core_req,
    input  logic               core_req_valid,
    output logic               core_req_ready,
    output dm_pkg::mem_rsp_t   core_rsp,
    output logic               core_rsp_valid,
    input  logic               core_rsp_ready,
    input  logic               going,
    input  logic               resume_req,
    input  dm_pkg::dm_word_t   data_rword,
    input  dm_pkg::dm_word_t   pbuf_rword,
    output logic [3:0]         data_ridx,
    output logic [3:0]         pbuf_ridx,
    output dm_pkg::bank_wr_t   data_wr,
    output dm_pkg::bank_wr_t   pbuf_wr,
    output dm_pkg::core_evt_t  core_evt
);
    import dm_pkg::*;

    logic      accept;
    logic      wr_acc;
    logic [3:0] word_idx;
    logic      sel_flag;
    logic      sel_whereto;
    logic      sel_data;
    logic      sel_pbuf;
    logic      sel_halt;
    logic      sel_going;
    logic      sel_resuming;
    logic      sel_exception;
    logic      rd_ok;
    logic      wr_ok;
    dm_word_t  rd_data;
    logic      rsp_valid_q;
    mem_rsp_t  rsp_q;

    assign accept   = core_req_valid & core_req_ready;
    assign wr_acc   = accept & core_req.write;
    assign word_idx = core_req.addr[5:2];

    assign sel_flag      = core_req.addr == ADDR_FLAGS;
    assign sel_whereto   = core_req.addr[11:2] == ADDR_WHERETO[11:2];
    assign sel_data      = (core_req.addr[11:6] == ADDR_DATA[11:6]) &&
                           ({1'b0, word_idx} < 5'(DATA_COUNT));
    assign sel_pbuf      = (core_req.addr[11:6] == ADDR_PROGBUF[11:6]) &&
                           ({1'b0, word_idx} < 5'(PROGBUF_COUNT));
    assign sel_halt      = core_req.addr == ADDR_HALT;
    assign sel_going     = core_req.addr == ADDR_GOING;
    assign sel_resuming  = core_req.addr == ADDR_RESUMING;
    assign sel_exception = core_req.addr == ADDR_EXCEPTION;

    // Event words are write-only, flag and whereto read-only
    assign rd_ok = sel_flag | sel_whereto | sel_data | sel_pbuf;
    assign wr_ok = sel_data | sel_pbuf | sel_halt | sel_going | sel_resuming | sel_exception;

    always_comb begin
        rd_data = '0;
        if (sel_flag) begin
            rd_data = {30'h0, resume_req, going};
        end else if (sel_whereto) begin
            rd_data = WHERETO_INSN;
        end else if (sel_data) begin
            rd_data = data_rword;
        end else if (sel_pbuf) begin
            rd_data = pbuf_rword;
        end
    end

    assign data_ridx = word_idx;
    assign pbuf_ridx = word_idx;

    assign data_wr = '{en: wr_acc & sel_data, idx: word_idx,
                       wdata: core_req.wdata, strb: core_req.strb};
    assign pbuf_wr = '{en: wr_acc & sel_pbuf, idx: word_idx,
                       wdata: core_req.wdata, strb: core_req.strb};

    assign core_evt = '{halt_wr:      wr_acc & sel_halt,
                        going_wr:     wr_acc & sel_going,
                        resuming_wr:  wr_acc & sel_resuming,
                        exception_wr: wr_acc & sel_exception};

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            rsp_valid_q <= 1'b0;
        end else if (accept) begin
            rsp_valid_q <= 1'b1;
        end else if (core_rsp_ready) begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge dm_clk) begin
        if (accept) begin
            if (core_req.write) begin
                rsp_q.err   <= ~wr_ok;
                rsp_q.rdata <= '0;
            end else begin
                rsp_q.err   <= ~rd_ok;
                rsp_q.rdata <= rd_data;
            end
        end
    end

    assign core_req_ready = ~rsp_valid_q; // One transaction in flight
    assign core_rsp_valid = rsp_valid_q;
    assign core_rsp       = rsp_q;

endmodule

/* dm_word_bank.sv */
`timescale 1ns/1ps

module dm_word_bank #(
    parameter int                COUNT = 12,
    parameter dm_pkg::dmi_addr_t BASE  = dm_pkg::DMI_DATA0
) (
    input  logic               dm_clk,
    input  logic               dm_rst_n,
    input  logic               dmactive,
    input  logic               busy,
    input  dm_pkg::dmi_req_t   dmi,
    input  dm_pkg::bank_wr_t   core_wr,
    input  logic [3:0]         ridx,
    output dm_pkg::dm_word_t   rword,
    output dm_pkg::dm_word_t   dtm_rword,
    output logic [COUNT-1:0]   dtm_hit
);
    import dm_pkg::*;

    dm_word_t   mem [COUNT];
    dmi_addr_t  dtm_idx;
    logic       dtm_in_range;
    logic       dtm_sel;
    logic [COUNT-1:0] dtm_wen;
    logic [COUNT-1:0] core_wen;
    dm_word_t   wmask;

    assign dtm_idx      = dmi.addr - BASE;
    assign dtm_in_range = (dmi.addr >= BASE) && (dtm_idx < 7'(COUNT));
    assign dtm_sel      = (dmi.wen | dmi.ren) & dtm_in_range;

    // Byte lanes from the hart strobes
    assign wmask = {{8{core_wr.strb[3]}}, {8{core_wr.strb[2]}},
                    {8{core_wr.strb[1]}}, {8{core_wr.strb[0]}}};

    for (genvar g = 0; g < COUNT; g++) begin : gen_entry
        assign dtm_hit[g]  = dtm_sel & (dtm_idx == 7'(g));
        assign dtm_wen[g]  = dtm_hit[g] & dmi.wen & ~busy;
        assign core_wen[g] = core_wr.en & (core_wr.idx == 4'(g));
    end

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            for (int i = 0; i < COUNT; i++) begin
                mem[i] <= '0;
            end
        end else if (!dmactive) begin
            for (int i = 0; i < COUNT; i++) begin
                mem[i] <= '0;
            end
        end else begin
            for (int i = 0; i < COUNT; i++) begin
                if (dtm_wen[i]) begin // Debugger wins a same-cycle clash
                    mem[i] <= dmi.data;
                end else if (core_wen[i]) begin
                    mem[i] <= (mem[i] & ~wmask) | (core_wr.wdata & wmask);
                end
            end
        end
    end

    assign rword     = ({1'b0, ridx} < 5'(COUNT)) ? mem[ridx] : '0;
    assign dtm_rword = dtm_in_range ? mem[dtm_idx[3:0]] : '0; // Unused index reads 0

endmodule

/* dm_cmd_ctrl.sv */
`timescale 1ns/1ps

module dm_cmd_ctrl #(
    parameter int DATA_COUNT    = 12,
    parameter int PROGBUF_COUNT = 16
) (
    input  logic                      dm_clk,
    input  logic                      dm_rst_n,
    input  logic                      dmactive,
    input  dm_pkg::dmi_req_t          dmi,
    input  dm_pkg::core_evt_t         core_evt,
    input  logic [DATA_COUNT-1:0]     data_hit,
    input  logic [PROGBUF_COUNT-1:0]  pbuf_hit,
    output logic                      busy,
    output logic                      going,
    output logic                      resume_req,
    output dm_pkg::dm_status_t        status,
    output dm_pkg::dm_word_t          hartinfo,
    output dm_pkg::dm_word_t          abstractcs,
    output dm_pkg::dm_word_t          command,
    output dm_pkg::dm_word_t          abstractauto
);
    import dm_pkg::*;

    dm_word_t                 command_q;
    cmderr_t                  cmderr;
    logic                     halted;
    logic                     resumeack;
    logic [DATA_COUNT-1:0]    auto_data;
    logic [PROGBUF_COUNT-1:0] auto_pbuf;
    logic                     cmd_wr;
    logic                     cs_wr;
    logic                     auto_wr;
    logic                     resume_wr;
    logic                     auto_hit;
    logic                     launch_req;
    logic                     launch_legal;
    logic                     start;
    logic                     finish;
    logic                     busy_err;

    // Access-register, 32-bit, regno in range
    function automatic logic cmd_legal(input dm_word_t w);
        return (w[31:24] == 8'h0) && (w[22:20] == 3'd2) && (w[15:0] < REGNO_LIMIT);
    endfunction

    assign cmd_wr    = dmi.wen & (dmi.addr == DMI_COMMAND);
    assign cs_wr     = dmi.wen & (dmi.addr == DMI_ABSTRACTCS);
    assign auto_wr   = dmi.wen & (dmi.addr == DMI_ABSTRACTAUTO);
    assign resume_wr = dmi.wen & (dmi.addr == DMI_DMCONTROL) & dmi.data[30] & dmi.data[0];
    assign auto_hit  = (|(data_hit & auto_data)) | (|(pbuf_hit & auto_pbuf));

    assign launch_req   = ~busy & (cmd_wr | auto_hit);
    assign launch_legal = cmd_wr ? cmd_legal(dmi.data) : cmd_legal(command_q);
    assign start        = launch_req & (cmderr == CMDERR_NONE) & halted & launch_legal;
    assign finish       = busy & core_evt.halt_wr & ~going; // Hart back in park loop
    assign busy_err     = busy & ((|data_hit) | (|pbuf_hit) | cmd_wr | auto_wr);

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            busy <= 1'b0;
        end else if (!dmactive) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (finish) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            going      <= 1'b0;
            resume_req <= 1'b0;
            halted     <= 1'b0;
            resumeack  <= 1'b0;
        end else begin
            if (core_evt.going_wr) begin
                going <= 1'b0;
            end else if (start) begin
                going <= 1'b1;
            end
            if (core_evt.resuming_wr) begin
                resume_req <= 1'b0;
                resumeack  <= 1'b1;
            end else if (resume_wr) begin
                resume_req <= 1'b1;
                resumeack  <= 1'b0;
            end
            if (core_evt.halt_wr) begin
                halted <= 1'b1;
            end else if (core_evt.resuming_wr) begin
                halted <= 1'b0;
            end
        end
    end

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            cmderr <= CMDERR_NONE;
        end else if (cs_wr) begin
            cmderr <= cmderr_t'(cmderr & ~dmi.data[10:8]); // W1C
        end else if (cmderr == CMDERR_NONE) begin
            if (core_evt.exception_wr) begin
                cmderr <= CMDERR_EXCEPTION;
            end else if (busy_err) begin
                cmderr <= CMDERR_BUSY;
            end else if (launch_req && !halted) begin
                cmderr <= CMDERR_HALTRESUME;
            end else if (launch_req && !launch_legal) begin
                cmderr <= CMDERR_NOTSUP;
            end
        end
    end

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            command_q <= '0;
            auto_data <= '0;
            auto_pbuf <= '0;
        end else if (!dmactive) begin
            command_q <= '0;
            auto_data <= '0;
            auto_pbuf <= '0;
        end else begin
            if (cmd_wr && !busy) begin
                command_q <= dmi.data;
            end else if (finish && command_q[19]) begin
                command_q <= {command_q[31:16], command_q[15:0] + 16'd1}; // aarpostincrement
            end
            if (auto_wr && !busy) begin
                auto_data <= dmi.data[DATA_COUNT-1:0];
                auto_pbuf <= dmi.data[16 +: PROGBUF_COUNT];
            end
        end
    end

    always_comb begin
        abstractauto = '0;
        abstractauto[DATA_COUNT-1:0]    = auto_data;
        abstractauto[16 +: PROGBUF_COUNT] = auto_pbuf;
    end

    assign status = '{allhalt: halted, anyhalt: halted,
                      allresumeack: resumeack, anyresumeack: resumeack};

    // nscratch, dataaccess, datasize, dataaddr
    assign hartinfo   = {8'h0, 4'(NSCRATCH), 3'h0, 1'b1, 4'(DATA_COUNT), ADDR_DATA};
    assign abstractcs = {3'h0, 5'(PROGBUF_COUNT), 11'h0, busy, 1'b0, cmderr,
                         4'h0, 4'(DATA_COUNT)};
    assign command    = command_q;

endmodule

/* dm_abstract_top.sv */
`timescale 1ns/1ps

module dm_abstract_top #(
    parameter int DATA_COUNT    = 12,
    parameter int PROGBUF_COUNT = 16
) (
    input  logic               dm_clk,
    input  logic               dm_rst_n,
    input  logic               dmactive,
    input  dm_pkg::dmi_req_t   dmi,
    input  dm_pkg::mem_req_t   core_req,
    input  logic               core_req_valid,
    output logic               core_req_ready,
    output dm_pkg::mem_rsp_t   core_rsp,
    output logic               core_rsp_valid,
    input  logic               core_rsp_ready,
    output dm_pkg::dm_status_t status,
    output dm_pkg::dm_word_t   hartinfo,
    output dm_pkg::dm_word_t   abstractcs,
    output dm_pkg::dm_word_t   command,
    output dm_pkg::dm_word_t   abstractauto,
    output dm_pkg::dm_word_t   dm_data,
    output dm_pkg::dm_word_t   dm_progbuf
);
    import dm_pkg::*;

    dm_word_t                 data_rword;
    dm_word_t                 pbuf_rword;
    logic [3:0]               data_ridx;
    logic [3:0]               pbuf_ridx;
    bank_wr_t                 data_wr;
    bank_wr_t                 pbuf_wr;
    core_evt_t                core_evt;
    logic                     busy;
    logic                     going;
    logic                     resume_req;
    logic [DATA_COUNT-1:0]    data_hit;
    logic [PROGBUF_COUNT-1:0] pbuf_hit;

    dm_core_port #(
        .DATA_COUNT    (DATA_COUNT),
        .PROGBUF_COUNT (PROGBUF_COUNT)
    ) u_port (
        .dm_clk         (dm_clk),
        .dm_rst_n       (dm_rst_n),
        .core_req       (core_req),
        .core_req_valid (core_req_valid),
        .core_req_ready (core_req_ready),
        .core_rsp       (core_rsp),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp_ready (core_rsp_ready),
        .going          (going),
        .resume_req     (resume_req),
        .data_rword     (data_rword),
        .pbuf_rword     (pbuf_rword),
        .data_ridx      (data_ridx),
        .pbuf_ridx      (pbuf_ridx),
        .data_wr        (data_wr),
        .pbuf_wr        (pbuf_wr),
        .core_evt       (core_evt)
    );

    dm_word_bank #(
        .COUNT (DATA_COUNT),
        .BASE  (DMI_DATA0)
    ) u_data (
        .dm_clk    (dm_clk),
        .dm_rst_n  (dm_rst_n),
        .dmactive  (dmactive),
        .busy      (busy),
        .dmi       (dmi),
        .core_wr   (data_wr),
        .ridx      (data_ridx),
        .rword     (data_rword),
        .dtm_rword (dm_data),
        .dtm_hit   (data_hit)
    );

    dm_word_bank #(
        .COUNT (PROGBUF_COUNT),
        .BASE  (DMI_PROGBUF0)
    ) u_pbuf (
        .dm_clk    (dm_clk),
        .dm_rst_n  (dm_rst_n),
        .dmactive  (dmactive),
        .busy      (busy),
        .dmi       (dmi),
        .core_wr   (pbuf_wr),
        .ridx      (pbuf_ridx),
        .rword     (pbuf_rword),
        .dtm_rword (dm_progbuf),
        .dtm_hit   (pbuf_hit)
    );

    dm_cmd_ctrl #(
        .DATA_COUNT    (DATA_COUNT),
        .PROGBUF_COUNT (PROGBUF_COUNT)
    ) u_ctrl (
        .dm_clk       (dm_clk),
        .dm_rst_n     (dm_rst_n),
        .dmactive     (dmactive),
        .dmi          (dmi),
        .core_evt     (core_evt),
        .data_hit     (data_hit),
        .pbuf_hit     (pbuf_hit),
        .busy         (busy),
        .going        (going),
        .resume_req   (resume_req),
        .status       (status),
        .hartinfo     (hartinfo),
        .abstractcs   (abstractcs),
        .command      (command),
        .abstractauto (abstractauto)
    );

endmodule

/* tb_dm_checks.svh */
int checks;
int errors;
int timeouts;

localparam int WAIT_LIMIT = 50; // Cycles per wait loop

task automatic check_word(input string name, input dm_word_t exp, input dm_word_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_rsp(input string name, input mem_rsp_t exp, input mem_rsp_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("ERROR %s: expected err=%b rdata=%h, actual err=%b rdata=%h",
                 name, exp.err, exp.rdata, act.err, act.rdata);
    end
endtask

task automatic check_status(input string name, input dm_status_t exp, input dm_status_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("ERROR %s: expected %b, actual %b", name, exp, act);
    end
endtask

task automatic dmi_write(input dmi_addr_t reg_addr, input dm_word_t wdata);
    @(negedge dm_clk);
    dmi = '{wen: 1'b1, ren: 1'b0, addr: reg_addr, data: wdata};
    @(negedge dm_clk);
    dmi = '0;
endtask

task automatic dmi_read(input dmi_addr_t reg_addr, output dm_word_t data_word,
                        output dm_word_t pbuf_word);
    @(negedge dm_clk);
    dmi = '{wen: 1'b0, ren: 1'b1, addr: reg_addr, data: '0};
    #1;
    data_word = dm_data; // Combinational from dmi.addr
    pbuf_word = dm_progbuf;
    @(negedge dm_clk);
    dmi = '0;
endtask

task automatic core_access(input mem_req_t req, output mem_rsp_t rsp, input string name);
    int n;
    rsp = '0;
    @(negedge dm_clk);
    core_req       = req;
    core_req_valid = 1'b1;
    n = 0;
    while (!core_req_ready && n < WAIT_LIMIT) begin
        @(negedge dm_clk);
        n++;
    end
    if (!core_req_ready) begin
        timeouts++;
        $display("Timeout: hart request %s was never accepted", name);
        core_req_valid = 1'b0;
    end else begin
        @(negedge dm_clk);
        core_req_valid = 1'b0; // Taken on the edge just passed
        n = 0;
        while (!core_rsp_valid && n < WAIT_LIMIT) begin
            @(negedge dm_clk);
            n++;
        end
        if (!core_rsp_valid) begin
            timeouts++;
            $display("Timeout: no response came back for hart request %s", name);
        end else begin
            rsp = core_rsp;
        end
    end
endtask

task automatic core_write(input mem_addr_t addr, input dm_word_t wdata, input logic [3:0] strb,
                          output mem_rsp_t rsp, input string name);
    core_access(mem_req_t'{write: 1'b1, addr: addr, wdata: wdata, strb: strb}, rsp, name);
endtask

task automatic core_read(input mem_addr_t addr, output mem_rsp_t rsp, input string name);
    core_access(mem_req_t'{write: 1'b0, addr: addr, wdata: '0, strb: 4'h0}, rsp, name);
endtask

task automatic wait_busy(input logic level, input string name);
    int n;
    n = 0;
    while (abstractcs[12] !== level && n < WAIT_LIMIT) begin
        @(negedge dm_clk);
        n++;
    end
    if (abstractcs[12] !== level) begin
        timeouts++;
        $display("Timeout: busy never became %0b in %s", level, name);
    end
endtask

/* tb_dm_abstract.sv */
`timescale 1ns/1ps

module tb_dm_abstract;
    import dm_pkg::*;

    localparam int DATA_COUNT    = 12;
    localparam int PROGBUF_COUNT = 16;

    logic       dm_clk;
    logic       dm_rst_n;
    logic       dmactive;
    dmi_req_t   dmi;
    mem_req_t   core_req;
    logic       core_req_valid;
    logic       core_req_ready;
    mem_rsp_t   core_rsp;
    logic       core_rsp_valid;
    logic       core_rsp_ready;
    dm_status_t status;
    dm_word_t   hartinfo;
    dm_word_t   abstractcs;
    dm_word_t   command;
    dm_word_t   abstractauto;
    dm_word_t   dm_data;
    dm_word_t   dm_progbuf;
    logic [15:0] lfsr_q;
    dm_word_t   exp_data [DATA_COUNT];
    dm_word_t   exp_pbuf [PROGBUF_COUNT];

    `include "tb_dm_checks.svh"

    dm_abstract_top #(
        .DATA_COUNT    (DATA_COUNT),
        .PROGBUF_COUNT (PROGBUF_COUNT)
    ) i_dut (
        .dm_clk         (dm_clk),
        .dm_rst_n       (dm_rst_n),
        .dmactive       (dmactive),
        .dmi            (dmi),
        .core_req       (core_req),
        .core_req_valid (core_req_valid),
        .core_req_ready (core_req_ready),
        .core_rsp       (core_rsp),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp_ready (core_rsp_ready),
        .status         (status),
        .hartinfo       (hartinfo),
        .abstractcs     (abstractcs),
        .command        (command),
        .abstractauto   (abstractauto),
        .dm_data        (dm_data),
        .dm_progbuf     (dm_progbuf)
    );

    always #2 dm_clk = ~dm_clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic next_word(output dm_word_t w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            w      = {w[30:0], lfsr_q[0]}; // One step per bit
        end
    endtask

    function automatic dm_word_t byte_mask(input logic [3:0] strb);
        dm_word_t m;
        m = '0;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                m[8*b +: 8] = 8'hff;
            end
        end
        return m;
    endfunction

    // Access-register command with transfer set
    function automatic dm_word_t make_cmd(input logic [2:0] size, input logic postinc,
                                          input logic [15:0] regno);
        return {8'h0, 1'b0, size, postinc, 1'b0, 1'b1, 1'b0, regno};
    endfunction

    task automatic reset_values();
        check_status("reset status", '0, status);
        check_word("reset cmderr", 32'd0, 32'(abstractcs[10:8]));
        check_word("reset busy", 32'd0, 32'(abstractcs[12]));
        check_word("reset datacount", 32'd12, 32'(abstractcs[3:0]));
        check_word("reset progbufsize", 32'd16, 32'(abstractcs[28:24]));
        check_word("hartinfo nscratch", 32'd2, 32'(hartinfo[23:20]));
        check_word("hartinfo datasize", 32'd12, 32'(hartinfo[15:12]));
        check_word("reset req ready", 32'd1, 32'(core_req_ready));
        check_word("reset rsp valid", 32'd0, 32'(core_rsp_valid));
    endtask

    task automatic dmi_reg_access();
        dm_word_t w;
        dm_word_t d;
        dm_word_t p;
        for (int i = 0; i < DATA_COUNT; i++) begin
            next_word(w);
            exp_data[i] = w;
            dmi_write(dmi_addr_t'(DMI_DATA0 + i), w);
        end
        for (int i = 0; i < PROGBUF_COUNT; i++) begin
            next_word(w);
            exp_pbuf[i] = w;
            dmi_write(dmi_addr_t'(DMI_PROGBUF0 + i), w);
        end
        for (int i = 0; i < DATA_COUNT; i++) begin
            dmi_read(dmi_addr_t'(DMI_DATA0 + i), d, p);
            check_word($sformatf("dmi data%0d", i), exp_data[i], d);
        end
        for (int i = 0; i < PROGBUF_COUNT; i++) begin
            dmi_read(dmi_addr_t'(DMI_PROGBUF0 + i), d, p);
            check_word($sformatf("dmi progbuf%0d", i), exp_pbuf[i], p);
        end
        dmi_read(dmi_addr_t'(DMI_DATA0 + DATA_COUNT), d, p);
        check_word("unused data index", '0, d);
        dmi_read(dmi_addr_t'(DMI_PROGBUF0 + PROGBUF_COUNT), d, p);
        check_word("unused progbuf index", '0, p);
    endtask

    task automatic core_port_access();
        mem_rsp_t rsp;
        dm_word_t w;
        dm_word_t d;
        dm_word_t p;
        next_word(w);
        exp_data[1] = (exp_data[1] & ~byte_mask(4'b0101)) | (w & byte_mask(4'b0101));
        core_write(ADDR_DATA + 12'h4, w, 4'b0101, rsp, "data1 write");
        check_word("data1 write err", 32'd0, 32'(rsp.err));
        core_read(ADDR_DATA + 12'h4, rsp, "data1 read");
        check_rsp("data1 read", mem_rsp_t'{err: 1'b0, rdata: exp_data[1]}, rsp);
        dmi_read(dmi_addr_t'(DMI_DATA0 + 1), d, p);
        check_word("data1 via dmi", exp_data[1], d);
        next_word(w);
        exp_pbuf[3] = (exp_pbuf[3] & ~byte_mask(4'b1100)) | (w & byte_mask(4'b1100));
        core_write(ADDR_PROGBUF + 12'hc, w, 4'b1100, rsp, "progbuf3 write");
        core_read(ADDR_PROGBUF + 12'hc, rsp, "progbuf3 read");
        check_rsp("progbuf3 read", mem_rsp_t'{err: 1'b0, rdata: exp_pbuf[3]}, rsp);
        core_read(ADDR_FLAGS, rsp, "flags read");
        check_rsp("flags idle", mem_rsp_t'{err: 1'b0, rdata: '0}, rsp);
        core_read(ADDR_WHERETO, rsp, "whereto read");
        check_rsp("whereto", mem_rsp_t'{err: 1'b0, rdata: WHERETO_INSN}, rsp);
        core_read(12'h200, rsp, "unmapped read");
        check_rsp("unmapped read", mem_rsp_t'{err: 1'b1, rdata: '0}, rsp);
        core_read(ADDR_DATA + 12'h30, rsp, "data12 read"); // Past DATA_COUNT
        check_rsp("data12 read", mem_rsp_t'{err: 1'b1, rdata: '0}, rsp);
        core_write(12'h200, w, 4'hf, rsp, "unmapped write");
        check_word("unmapped write err", 32'd1, 32'(rsp.err));
    endtask

    task automatic command_errors();
        mem_rsp_t rsp;
        dm_word_t d;
        dm_word_t p;
        dmi_write(DMI_COMMAND, make_cmd(3'd2, 1'b0, 16'h1000)); // Hart still running
        check_word("cmderr not halted", 32'd4, 32'(abstractcs[10:8]));
        dmi_write(DMI_ABSTRACTCS, 32'h0000_0700);
        check_word("cmderr cleared", 32'd0, 32'(abstractcs[10:8]));
        core_write(ADDR_HALT, '0, 4'hf, rsp, "halt write");
        dmi_write(DMI_COMMAND, make_cmd(3'd3, 1'b0, 16'h1000));
        check_word("cmderr bad aarsize", 32'd2, 32'(abstractcs[10:8]));
        check_word("bad aarsize busy", 32'd0, 32'(abstractcs[12]));
        dmi_write(DMI_ABSTRACTCS, 32'h0000_0700);
        dmi_write(DMI_COMMAND, make_cmd(3'd2, 1'b0, 16'h1000));
        wait_busy(1'b1, "busy launch");
        dmi_write(DMI_COMMAND, make_cmd(3'd2, 1'b0, 16'h1001));
        check_word("cmderr busy", 32'd1, 32'(abstractcs[10:8]));
        dmi_write(DMI_ABSTRACTCS, 32'h0000_0700);
        check_word("cmderr cleared while busy", 32'd0, 32'(abstractcs[10:8]));
        core_write(ADDR_EXCEPTION, '0, 4'hf, rsp, "exception write");
        check_word("cmderr exception", 32'd3, 32'(abstractcs[10:8]));
        core_write(ADDR_GOING, '0, 4'hf, rsp, "going write");
        core_write(ADDR_HALT, '0, 4'hf, rsp, "halt write");
        wait_busy(1'b0, "exception finish");
        dmi_write(DMI_ABSTRACTCS, 32'h0000_0700);
        dmi_write(DMI_ABSTRACTAUTO, 32'h0001_0001); // Autoexec on data0 and progbuf0
        check_word("abstractauto set", 32'h0001_0001, abstractauto);
        dmi_read(DMI_DATA0, d, p);
        wait_busy(1'b1, "autoexec launch");
        core_write(ADDR_GOING, '0, 4'hf, rsp, "going write");
        core_write(ADDR_HALT, '0, 4'hf, rsp, "halt write");
        wait_busy(1'b0, "autoexec finish");
        dmi_write(DMI_ABSTRACTAUTO, 32'h0);
        check_word("abstractauto cleared", 32'h0, abstractauto);
        check_word("cmderr after autoexec", 32'd0, 32'(abstractcs[10:8]));
    endtask

    task automatic command_flow();
        mem_rsp_t rsp;
        core_write(ADDR_HALT, '0, 4'hf, rsp, "halt write");
        check_status("halted", dm_status_t'{allhalt: 1'b1, anyhalt: 1'b1, allresumeack: 1'b0,
                     anyresumeack: 1'b0}, status);
        dmi_write(DMI_COMMAND, make_cmd(3'd2, 1'b1, 16'h1000));
        wait_busy(1'b1, "command launch");
        core_read(ADDR_FLAGS, rsp, "flags read");
        check_rsp("flags going", mem_rsp_t'{err: 1'b0, rdata: 32'h1}, rsp);
        core_write(ADDR_GOING, '0, 4'hf, rsp, "going write");
        core_read(ADDR_FLAGS, rsp, "flags read");
        check_rsp("flags after going", mem_rsp_t'{err: 1'b0, rdata: '0}, rsp);
        core_write(ADDR_HALT, '0, 4'hf, rsp, "halt write");
        wait_busy(1'b0, "command finish");
        check_word("regno postincrement", make_cmd(3'd2, 1'b1, 16'h1001), command);
        check_word("cmderr after command", 32'd0, 32'(abstractcs[10:8]));
    endtask

    task automatic resume_flow();
        mem_rsp_t rsp;
        dmi_write(DMI_DMCONTROL, 32'h4000_0001); // resumereq with dmactive
        core_read(ADDR_FLAGS, rsp, "flags read");
        check_rsp("flags resume", mem_rsp_t'{err: 1'b0, rdata: 32'h2}, rsp);
        core_write(ADDR_RESUMING, '0, 4'hf, rsp, "resuming write");
        check_status("resumed", dm_status_t'{allhalt: 1'b0, anyhalt: 1'b0, allresumeack: 1'b1,
                     anyresumeack: 1'b1}, status);
    endtask

    initial begin
        #100000;
        $display("Simulation time limit reached before the tests completed");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        dm_clk         = 1'b0;
        dm_rst_n       = 1'b0;
        dmactive       = 1'b1;
        dmi            = '0;
        core_req       = '0;
        core_req_valid = 1'b0;
        core_rsp_ready = 1'b1;
        lfsr_q         = 16'd49;
        repeat (2) @(negedge dm_clk);
        dm_rst_n = 1'b1;
        reset_values();
        dmi_reg_access();
        core_port_access();
        command_errors();
        command_flow();
        resume_flow();
        @(negedge dm_clk);
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+.
dm_pkg.sv
dm_core_port.sv
dm_word_bank.sv
dm_cmd_ctrl.sv
dm_abstract_top.sv
tb_dm_abstract.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f compile.f \
    --top-module tb_dm_abstract --Mdir obj_dir -o tb_dm_abstract

./obj_dir/tb_dm_abstract > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail"
    exit 1
fi
